// File: sim.f
+incdir+include
design/bch_pkg.sv
design/bch_lfsr_counter.sv
design/bch_encoder.sv
design/bch_syndrome.sv
design/bch_codec_top.sv
dv/bch_codec_tb.sv

// File: include/bch_tb_model.svh
// ============================
// bch reference model
// plain behavioural encoder, syndromes, classification and a
// 32-bit Fibonacci LFSR for the codec testbench
// ============================

`ifndef BCH_TB_MODEL_SVH
`define BCH_TB_MODEL_SVH

// remainder of data times x^8 by long division with the generator
function automatic logic [bch_pkg::ecc_bits-1:0] model_parity(
	input logic [bch_pkg::data_k-1:0] data
);
	logic [bch_pkg::code_n-1:0] dividend;
	dividend = {data, {bch_pkg::ecc_bits{1'b0}}};
	for (int i = bch_pkg::code_n - 1; i >= bch_pkg::ecc_bits; i--) begin
		if (dividend[i])
			dividend = dividend ^ (15'(bch_pkg::gen_poly) << (i - bch_pkg::ecc_bits));
	end
	return dividend[bch_pkg::ecc_bits-1:0];
endfunction

// systematic codeword with bit 14 sent first
function automatic logic [bch_pkg::code_n-1:0] model_codeword(
	input logic [bch_pkg::data_k-1:0] data
);
	return {data, model_parity(data)};
endfunction

// sum of root^j over the set bits, root is alpha or alpha cubed
function automatic logic [bch_pkg::gf_m-1:0] model_syndrome(
	input logic [bch_pkg::code_n-1:0] word,
	input logic [bch_pkg::gf_m-1:0] root
);
	logic [bch_pkg::gf_m-1:0] sum;
	logic [bch_pkg::gf_m-1:0] power;
	sum = '0;
	power = 4'h1;
	for (int j = 0; j < bch_pkg::code_n; j++) begin
		if (word[j])
			sum = sum ^ power;
		power = bch_pkg::gf_mul(power, root);
	end
	return sum;
endfunction

function automatic bch_pkg::bch_status_e model_status(
	input logic [bch_pkg::gf_m-1:0] s1,
	input logic [bch_pkg::gf_m-1:0] s3
);
	if (s1 == '0 && s3 == '0)
		return bch_pkg::clean;
	if (s1 != '0 && s3 == bch_pkg::gf_cube(s1))
		return bch_pkg::single_err;
	return bch_pkg::multi_err;
endfunction

// taps for x^32+x^22+x^2+x+1
function automatic logic [31:0] lfsr32_next(input logic [31:0] state);
	return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

`endif

// File: dv/bch_codec_tb.sv
// ============================
// bch codec testbench
// encodes table entries, flips bits by mask and checks the
// syndromes and class against the reference model
// ============================

module bch_codec_tb;
	import bch_pkg::*;
	`include "bch_tb_model.svh"

	localparam int clk_half = 10;
	localparam int num_directed = 8;
	localparam int num_random = 5;
	localparam int cycles_per_entry = 2000;
	localparam int valid_wait = 20;           // cycles allowed for chk_valid

	typedef struct packed {
		logic [data_k-1:0] data;
		logic [code_n-1:0] mask;               // bits flipped before the checker
		logic [code_n-1:0] gaps;               // bit k-1 puts an idle cycle before bit k
		logic spurious_start;                  // extra start on bit 4 that must be ignored
		logic [code_n-1:0] exp_code;
		logic [gf_m-1:0] exp_s1;
		logic [gf_m-1:0] exp_s3;
		bch_status_e exp_status;
	} test_vec_t;

	logic clk;
	logic reset;
	logic enc_start;
	logic enc_ce;
	logic enc_data;
	logic enc_ready;
	bch_enc_out_t enc_out;
	logic chk_start;
	logic chk_ce;
	logic chk_bit;
	logic chk_valid;
	bch_check_t chk_result;

	test_vec_t vectors[$];
	logic [31:0] lfsr_state = 32'h0ef51459;
	logic [code_n-1:0] captured;              // codeword as it left the encoder
	int checks = 0;
	int value_errors = 0;
	int protocol_errors = 0;
	int cur_entry = -1;
	int cur_bit = 0;

	bch_codec_top bch_codec_top_inst (
		.clk(clk),
		.reset(reset),
		.enc_start(enc_start),
		.enc_ce(enc_ce),
		.enc_data(enc_data),
		.enc_ready(enc_ready),
		.enc_out(enc_out),
		.chk_start(chk_start),
		.chk_ce(chk_ce),
		.chk_bit(chk_bit),
		.chk_valid(chk_valid),
		.chk_result(chk_result)
	);

	initial clk = 1'b0;
	always #(clk_half) clk = ~clk;

	// ============================
	// helpers
	// ============================
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr32_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};  // one step per bit
		end
		return value;
	endfunction

	function automatic void add_entry(input logic [data_k-1:0] data,
			input logic [code_n-1:0] mask, input logic [code_n-1:0] gaps, input logic spurious);
		test_vec_t v;
		logic [code_n-1:0] received;
		v.data = data;
		v.mask = mask;
		v.gaps = gaps;
		v.spurious_start = spurious;
		v.exp_code = model_codeword(data);
		received = v.exp_code ^ mask;
		v.exp_s1 = model_syndrome(received, gf_alpha);
		v.exp_s3 = model_syndrome(received, gf_alpha3);
		v.exp_status = model_status(v.exp_s1, v.exp_s3);
		vectors.push_back(v);
	endfunction

	task automatic compare_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			value_errors++;
			$display("FAIL %s: got 0x%0h expected 0x%0h (entry %0d, bit %0d)",
				name, got, exp, cur_entry, cur_bit);
		end
	endtask

	task automatic idle_inputs();
		@(negedge clk);
		enc_ce = 1'b0;
		enc_start = 1'b0;
		chk_ce = 1'b0;
		chk_start = 1'b0;
		#(clk_half / 2);
	endtask

	// drives bit k of the codeword and a junk data bit in the parity cycles
	task automatic step_encoder(input test_vec_t v, input int k, input logic ce);
		@(negedge clk);
		enc_ce = ce;
		enc_start = (k == 1) || (v.spurious_start && k == 4);
		enc_data = (k <= data_k) ? v.data[data_k - k] : v.data[k % data_k];
		#(clk_half / 2);
	endtask

	// ============================
	// encoder and checker passes
	// ============================
	task automatic encode_entry(input test_vec_t v);
		bch_enc_out_t held_out;
		logic held_ready;
		for (int k = 1; k <= code_n; k++) begin
			cur_bit = k;
			if (v.gaps[k-1]) begin
				step_encoder(v, k, 1'b0);
				held_out = enc_out;
				held_ready = enc_ready;
			end
			step_encoder(v, k, 1'b1);
			if (v.gaps[k-1]) begin
				compare_hex("enc_out held", enc_out, held_out);
				compare_hex("enc_ready held", enc_ready, held_ready);
			end
			captured[code_n-k] = enc_out.code_bit;
			compare_hex("enc_out.code_bit", enc_out.code_bit, v.exp_code[code_n-k]);
			compare_hex("enc_out.first", enc_out.first, k == 1);
			compare_hex("enc_out.last", enc_out.last, k == code_n);
			compare_hex("enc_out.data_phase", enc_out.data_phase, k <= data_k);
			compare_hex("enc_out.ecc_phase", enc_out.ecc_phase, k > data_k);
			compare_hex("enc_ready", enc_ready, k == 1);    // low once the start is taken
		end
		cur_bit = code_n + 1;
		idle_inputs();
		compare_hex("enc_ready", enc_ready, 1'b1);
		compare_hex("enc_out flags", enc_out[3:0], 4'h0);
	endtask

	task automatic feed_checker(input test_vec_t v);
		logic [code_n-1:0] received;
		logic [code_n-1:0] gaps;
		bch_check_t prev;
		int waited;
		logic seen;
		received = captured ^ v.mask;
		gaps = {v.gaps[0], v.gaps[code_n-1:1]};    // rotated so both paths differ
		prev = chk_result;
		seen = 1'b0;
		for (int k = 1; k <= code_n; k++) begin
			cur_bit = k;
			if (gaps[k-1]) begin
				@(negedge clk);
				chk_ce = 1'b0;
				chk_start = 1'b0;
				chk_bit = received[code_n-k];
				#(clk_half / 2);
				compare_hex("chk_valid", chk_valid, 1'b0);
				compare_hex("chk_result held", chk_result, prev);
			end
			@(negedge clk);
			chk_ce = 1'b1;
			chk_start = (k == 1);
			chk_bit = received[code_n-k];
			#(clk_half / 2);
			compare_hex("chk_valid", chk_valid, 1'b0);
			compare_hex("chk_result held", chk_result, prev);
		end
		cur_bit = code_n + 1;
		for (waited = 0; waited < valid_wait && !seen; waited++) begin
			idle_inputs();
			seen = chk_valid;
		end
		checks++;
		assert (seen) else begin
			protocol_errors++;
			$display("entry %0d: chk_valid did not pulse within %0d cycles after the last bit",
				cur_entry, valid_wait);
		end
		if (seen) begin
			compare_hex("chk_valid latency", waited, 1);
			compare_hex("chk_result.s1", chk_result.s1, v.exp_s1);
			compare_hex("chk_result.s3", chk_result.s3, v.exp_s3);
			compare_hex("chk_result.status", chk_result.status, v.exp_status);
			prev = chk_result;
			idle_inputs();
			compare_hex("chk_valid", chk_valid, 1'b0);      // a single cycle pulse
			compare_hex("chk_result held", chk_result, prev);
		end
	endtask

	// ============================
	// stimulus table and main flow
	// ============================
	initial begin
		logic [3:0] pos_a;
		logic [3:0] pos_b;
		logic [data_k-1:0] rnd_data;
		logic [code_n-1:0] rnd_mask;
		logic [code_n-1:0] rnd_gaps;
		logic rnd_spurious;
		reset = 1'b1;
		enc_start = 1'b0;
		enc_ce = 1'b0;
		enc_data = 1'b0;
		chk_start = 1'b0;
		chk_ce = 1'b0;
		chk_bit = 1'b0;

		add_entry(7'h00, 15'h0000, 15'h0000, 1'b0);     // all zero word
		add_entry(7'h5a, 15'h0000, 15'h0000, 1'b0);
		add_entry(7'h5a, 15'h0000, 15'h2a55, 1'b1);     // same data with gaps
		add_entry(7'h7f, 15'h0001, 15'h0000, 1'b0);     // single error at the lowest degree
		add_entry(7'h33, 15'h4000, 15'h0000, 1'b1);
		add_entry(7'h41, 15'h0100, 15'h1111, 1'b0);
		add_entry(7'h2c, 15'h0042, 15'h0000, 1'b0);     // double error
		add_entry(7'h66, 15'h4001, 15'h7fff, 1'b1);     // idle before every bit
		for (int r = 0; r < num_random; r++) begin
			rnd_data = data_k'(take_bits(data_k));
			rnd_gaps = code_n'(take_bits(code_n));
			rnd_spurious = 1'(take_bits(1));
			pos_a = 4'(take_bits(4) % code_n);
			pos_b = 4'(take_bits(4) % code_n);
			case (r % 3)
				0: rnd_mask = code_n'(take_bits(code_n));
				1: rnd_mask = 15'h0001 << pos_a;
				default: rnd_mask = (15'h0001 << pos_a) | (15'h0001 << pos_b);
			endcase
			add_entry(rnd_data, rnd_mask, rnd_gaps, rnd_spurious);
		end

		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		#(clk_half / 2);
		compare_hex("enc_ready", enc_ready, 1'b1);
		compare_hex("enc_out flags", enc_out[3:0], 4'h0);
		compare_hex("chk_valid", chk_valid, 1'b0);

		foreach (vectors[i]) begin
			cur_entry = i;
			encode_entry(vectors[i]);
			feed_checker(vectors[i]);
		end

		$display("checks %0d, value errors %0d, protocol errors %0d",
			checks, value_errors, protocol_errors);
		if (value_errors + protocol_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// stops a run that hangs on a missing pulse
	initial begin
		repeat (cycles_per_entry * (num_directed + num_random)) @(posedge clk);
		$display("watchdog: run did not finish in %0d cycles, stuck in entry %0d",
			cycles_per_entry * (num_directed + num_random), cur_entry);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: design/bch_codec_top.sv
// ============================
// bch codec top level
// serial encoder and syndrome checker on two independent paths
// ============================

module bch_codec_top (
	input logic clk,
	input logic reset,

	// encoder path
	input logic enc_start,
	input logic enc_ce,
	input logic enc_data,
	output logic enc_ready,
	output bch_pkg::bch_enc_out_t enc_out,

	// checker path
	input logic chk_start,
	input logic chk_ce,
	input logic chk_bit,
	output logic chk_valid,
	output bch_pkg::bch_check_t chk_result
);

	// ============================
	// encoder
	// ============================
	bch_encoder bch_encoder_inst (
		.clk(clk),
		.reset(reset),
		.start(enc_start),
		.ce(enc_ce),
		.data(enc_data),
		.ready(enc_ready),
		.enc_out(enc_out)
	);

	// ============================
	// checker
	// ============================
	bch_syndrome bch_syndrome_inst (
		.clk(clk),
		.reset(reset),
		.start(chk_start),
		.ce(chk_ce),
		.code_bit(chk_bit),          // highest degree bit arrives first
		.valid(chk_valid),
		.result(chk_result)
	);

endmodule

// File: design/bch_syndrome.sv
// ============================
// bch syndrome checker
// accumulates S1 and S3 over a serial 15-bit word and sorts it
// into clean, single error or uncorrectable
// ============================

module bch_syndrome (
	input logic clk,
	input logic reset,
	input logic start,
	input logic ce,
	input logic code_bit,
	output logic valid,
	output bch_pkg::bch_check_t result
);
	import bch_pkg::*;

	logic [gf_m-1:0] s1;              // r(alpha) so far
	logic [gf_m-1:0] s3;              // r(alpha^3) so far
	logic [gf_m-1:0] s1_next;
	logic [gf_m-1:0] s3_next;
	logic [gf_m-1:0] bit_term;
	logic [3:0] bit_count;            // bits taken in this word
	logic active;

	logic take_first;
	logic take_more;
	logic take_final;
	bch_status_e status_next;

	// ============================
	// bit acceptance
	// ============================
	assign take_first = ce && start;
	assign take_more = ce && active && !start;
	assign take_final = take_more && (bit_count == 4'(code_n - 1));

	assign bit_term = {{(gf_m - 1){1'b0}}, code_bit};

	// ============================
	// horner steps
	// ============================
	always_comb begin
		if (take_first) begin
			s1_next = bit_term;              // highest degree bit starts the sum
			s3_next = bit_term;
		end else begin
			s1_next = gf_mul(s1, gf_alpha) ^ bit_term;
			s3_next = gf_mul(s3, gf_alpha3) ^ bit_term;
		end
	end

	// a single error at position j gives S1 = alpha^j and S3 = S1 cubed
	always_comb begin
		if (s1_next == '0 && s3_next == '0) begin
			status_next = clean;
		end else if (s1_next != '0 && s3_next == gf_cube(s1_next)) begin
			status_next = single_err;
		end else begin
			status_next = multi_err;
		end
	end

	always_ff @(posedge clk) begin
		if (take_first || take_more) begin
			s1 <= s1_next;
			s3 <= s3_next;
		end
	end

	// ============================
	// word framing
	// ============================
	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			bit_count <= 4'd0;
			valid <= 1'b0;
		end else begin
			valid <= take_final;             // one cycle pulse after bit 15
			if (take_first) begin
				active <= 1'b1;
				bit_count <= 4'd1;
			end else if (take_more) begin
				bit_count <= bit_count + 4'd1;
				if (take_final)
					active <= 1'b0;
			end
		end
	end

	// result holds until the next word completes
	always_ff @(posedge clk) begin
		if (take_final) begin
			result.s1 <= s1_next;
			result.s3 <= s3_next;
			result.status <= status_next;
		end
	end

endmodule

// File: design/bch_encoder.sv
// ============================
// bch serial encoder
// passes 7 data bits straight through, then shifts out the 8 parity bits
// left in an LFSR that divides by the generator polynomial
// ============================

module bch_encoder (
	input logic clk,
	input logic reset,
	input logic start,
	input logic ce,
	input logic data,
	output logic ready,
	output bch_pkg::bch_enc_out_t enc_out
);
	import bch_pkg::*;

	logic [ecc_bits-1:0] parity;      // running remainder
	logic busy;                       // inside a codeword after the start cycle
	logic data_flag;                  // cycles 2 to 7 carry data
	logic last_flag;                  // cycle 15 is being output

	logic first_cycle;
	logic accept;
	logic data_phase;
	logic feedback;
	logic [ecc_bits-1:0] poly_term;
	logic [3:0] count;

	// ============================
	// input side
	// ============================

	// a start while busy is simply ignored
	assign first_cycle = start && !busy;
	assign accept = ce && first_cycle;

	// on the start cycle the remainder is taken as zero
	assign feedback = data ^ (first_cycle ? 1'b0 : parity[ecc_bits-1]);
	assign poly_term = feedback ? gen_poly[ecc_bits-1:0] : '0;

	bch_lfsr_counter bch_lfsr_counter_inst (
		.clk(clk),
		.reset(reset),
		.restart(accept),
		.ce(ce && busy),
		.count(count)
	);

	// ============================
	// control state
	// ============================
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			data_flag <= 1'b0;
			last_flag <= 1'b0;
		end else if (ce) begin
			if (first_cycle) begin
				busy <= 1'b1;
				data_flag <= 1'b1;           // six more data bits follow
			end else if (last_flag) begin
				busy <= 1'b0;                // ready again on the next cycle
				last_flag <= 1'b0;
			end else if (busy && count == done_state) begin
				last_flag <= 1'b1;
			end

			if (data_flag && count == switch_state)
				data_flag <= 1'b0;           // seventh data bit is going out now
		end
	end

	// ============================
	// parity register
	// ============================
	always_ff @(posedge clk) begin
		if (ce) begin
			if (first_cycle) begin
				parity <= poly_term;
			end else if (data_flag) begin
				parity <= {parity[ecc_bits-2:0], 1'b0} ^ poly_term;
			end else if (busy) begin
				parity <= {parity[ecc_bits-2:0], 1'b0};  // zero fill while draining
			end
		end
	end

	// ============================
	// outputs
	// ============================
	assign data_phase = first_cycle || data_flag;

	assign ready = !busy;

	assign enc_out.first = first_cycle;
	assign enc_out.last = last_flag;
	assign enc_out.data_phase = data_phase;
	assign enc_out.ecc_phase = busy && !data_flag;
	// highest degree parity bit leaves first
	assign enc_out.code_bit = data_phase ? data : parity[ecc_bits-1];

endmodule

// File: design/bch_lfsr_counter.sv
// ============================
// bch cycle counter
// 4-bit maximal length LFSR that runs through the 15 states of one codeword
// ============================

module bch_lfsr_counter (
	input logic clk,
	input logic reset,
	input logic restart,
	input logic ce,
	output logic [3:0] count
);
	import bch_pkg::*;

	logic [3:0] count_next;

	// a single xor per step, cheaper than a binary adder
	assign count_next = lfsr_step(count);

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= lfsr_seed;
		end else if (restart) begin
			count <= lfsr_seed;           // new codeword starts from the seed
		end else if (ce) begin
			count <= count_next;          // one step per accepted cycle
		end
	end

endmodule

// File: design/bch_pkg.sv
// ============================
// bch codec package
// code sizes, GF(16) arithmetic and the types shared by
// the BCH(15,7) encoder, the syndrome checker and the testbench
// ============================

package bch_pkg;

	// ============================
	// code constants
	// ============================
	localparam int code_n = 15;                    // codeword length
	localparam int data_k = 7;                     // data bits per codeword
	localparam int ecc_bits = code_n - data_k;     // parity bits per codeword
	localparam int gf_m = 4;                       // field element width

	localparam logic [ecc_bits:0] gen_poly = 9'b1_1101_0001;  // x^8+x^7+x^6+x^4+1
	localparam logic [gf_m:0] prim_poly = 5'b1_0011;          // x^4+x+1

	localparam logic [gf_m-1:0] gf_alpha = 4'h2;   // alpha
	localparam logic [gf_m-1:0] gf_alpha3 = 4'h8;  // alpha cubed

	localparam logic [3:0] lfsr_seed = 4'b0001;    // cycle counter state after restart

	// ============================
	// helper functions
	// ============================

	// one step of the cycle counter, taps for x^4+x^3+1
	function automatic logic [3:0] lfsr_step(input logic [3:0] state);
		return {state[2:0], state[3] ^ state[2]};
	endfunction

	// counter state after a number of steps from the seed
	function automatic logic [3:0] lfsr_count(input int steps);
		logic [3:0] state;
		state = lfsr_seed;
		for (int i = 0; i < steps; i++) begin
			state = lfsr_step(state);
		end
		return state;
	endfunction

	// shift and add multiply, reduced by the field polynomial
	function automatic logic [gf_m-1:0] gf_mul(input logic [gf_m-1:0] a, input logic [gf_m-1:0] b);
		logic [gf_m-1:0] prod;
		logic [gf_m-1:0] term;
		prod = '0;
		term = a;
		for (int i = 0; i < gf_m; i++) begin
			if (b[i])
				prod = prod ^ term;
			term = {term[gf_m-2:0], 1'b0} ^ (term[gf_m-1] ? prim_poly[gf_m-1:0] : '0);
		end
		return prod;
	endfunction

	function automatic logic [gf_m-1:0] gf_cube(input logic [gf_m-1:0] a);
		return gf_mul(gf_mul(a, a), a);
	endfunction

	// the encoder leaves the data phase when the counter shows this in cycle 7
	localparam logic [3:0] switch_state = lfsr_count(data_k - 2);
	// last is raised for cycle 15 when the counter shows this in cycle 14
	localparam logic [3:0] done_state = lfsr_count(code_n - 3);

	// ============================
	// shared types
	// ============================
	typedef enum logic [1:0] {
		clean = 2'd0,       // both syndromes zero
		single_err = 2'd1,  // exactly one bit flipped
		multi_err = 2'd2    // two flips or a pattern beyond the code
	} bch_status_e;

	typedef struct packed {
		logic code_bit;     // codeword bit of this cycle
		logic first;        // first output cycle
		logic last;         // fifteenth output cycle
		logic data_phase;   // bit is a data bit
		logic ecc_phase;    // bit is a parity bit
	} bch_enc_out_t;

	typedef struct packed {
		logic [gf_m-1:0] s1;
		logic [gf_m-1:0] s3;
		bch_status_e status;
	} bch_check_t;

endpackage
